// ==== sim.f ====
+incdir+verilog
verilog/neuralPkg.sv
verilog/denseNeuron.sv
verilog/scorePicker.sv
verilog/classifierTop.sv
verif/classifier_assert.sv
verif/classifierTb.sv

// ==== Bender.yml ====
package:
  name: classifier

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/neuralPkg.sv
      - verilog/denseNeuron.sv
      - verilog/scorePicker.sv
      - verilog/classifierTop.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verif/classifier_assert.sv
      - verif/classifierTb.sv

// ==== verif/classifierTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "neural_defines.svh"

module classifierTb
	import neuralPkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int LATENCY = 4;
	localparam int RANDOM_COUNT = 200;

	typedef logic [`NUM_INPUTS-1:0][`ACT_WIDTH-1:0] actWord_t;

	typedef struct
	{
		string name;
		logic valid;
		actWord_t act;
		int idleAfter; // Idle cycles driven after this entry
		bit handChecked; // Decision below was worked out by hand
		decision_t expected;
	} stimEntry_t;

	typedef struct
	{
		string name;
		decision_t expected;
		int dueCycle;
	} pending_t;

	logic clk = 1'b0;
	logic reset;
	actVector_t sample;
	decision_t decision;

	stimEntry_t stimTable[$];
	pending_t pendingQ[$];
	bit tableReady = 1'b0;
	int cycleCount = 0;
	int errorCount = 0;
	int testsDone = 0;
	int validCount = 0;

	classifierTop u_classifierTop (
		.clk (clk),
		.reset (reset),
		.sample (sample),
		.decision (decision)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	// ------------------------------
	// Reference model
	// ------------------------------

	function automatic int classScore(actWord_t act, weightTable_t weights, int bias);
		int sum;
		int score;
		sum = bias;
		for (int i = 0; i < `NUM_INPUTS; i++)
			sum += int'($signed(act[i])) * int'($signed(weights[i]));
		if (sum < 0)
			return 0;
		score = (sum + (1 << (`FRAC_BITS - 1))) >>> `FRAC_BITS; // Round half up
		return (score > `SCORE_MAX) ? `SCORE_MAX : score;
	endfunction

	function automatic decision_t predictDecision(actWord_t act);
		int s0;
		int s1;
		decision_t d;
		s0 = classScore(act, CLASS0_WEIGHTS, CLASS0_BIAS);
		s1 = classScore(act, CLASS1_WEIGHTS, CLASS1_BIAS);
		d.valid = 1'b1;
		d.classId = s1 > s0;
		d.score = (s1 > s0) ? s1[`ACT_WIDTH-1:0] : s0[`ACT_WIDTH-1:0];
		d.margin = (s1 > s0) ? `ACT_WIDTH'(s1 - s0) : `ACT_WIDTH'(s0 - s1);
		return d;
	endfunction

	// ------------------------------
	// Stimulus table
	// ------------------------------

	function automatic actWord_t twoHot(int idxA, int valA, int idxB, int valB);
		actWord_t act;
		act = '0;
		act[idxA] = `ACT_WIDTH'(valA);
		act[idxB] = `ACT_WIDTH'(valB);
		return act;
	endfunction

	// Every activation on the rail that pushes this class's sum up or down
	function automatic actWord_t railPattern(weightTable_t weights, bit drivePositive);
		actWord_t act;
		for (int i = 0; i < `NUM_INPUTS; i++)
			act[i] = (($signed(weights[i]) > 0) == drivePositive) ? 8'h7F : 8'h80;
		return act;
	endfunction

	task automatic addEntry(input string name, input logic valid, input actWord_t act,
		input int idleAfter, input bit handChecked = 1'b0, input int classId = 0,
		input int score = 0, input int margin = 0);
		stimEntry_t entry;
		entry.name = name;
		entry.valid = valid;
		entry.act = act;
		entry.idleAfter = idleAfter;
		entry.handChecked = handChecked;
		entry.expected.valid = 1'b1;
		entry.expected.classId = classId[0];
		entry.expected.score = score[`ACT_WIDTH-1:0];
		entry.expected.margin = margin[`ACT_WIDTH-1:0];
		stimTable.push_back(entry);
	endtask

	task automatic buildTable();
		actWord_t act;
		// Name, valid, activations, idle after, then class, score and margin when hand-worked
		addEntry("all zero", 1'b1, '0, 0, 1'b1, 0, 0, 0);
		addEntry("class0 rails up", 1'b1, railPattern(CLASS0_WEIGHTS, 1'b1), 0);
		addEntry("class0 rails down", 1'b1, railPattern(CLASS0_WEIGHTS, 1'b0), 1);
		addEntry("class1 rails up", 1'b1, railPattern(CLASS1_WEIGHTS, 1'b1), 0);
		addEntry("class1 rails down", 1'b1, railPattern(CLASS1_WEIGHTS, 1'b0), 2);
		addEntry("class0 overflow", 1'b1, twoHot(0, 127, 5, 127), 0, 1'b1, 0, 127, 127);
		addEntry("round past ceiling", 1'b1, twoHot(0, 127, 5, 15), 0, 1'b1, 0, 127, 127);
		addEntry("round up 6.53", 1'b1, twoHot(0, 15, 1, 0), 0, 1'b1, 0, 7, 7);
		addEntry("round half 7.5", 1'b1, twoHot(0, 16, 1, 0), 0, 1'b1, 0, 8, 8);
		addEntry("round down 8.47", 1'b1, twoHot(0, 17, 1, 0), 1, 1'b1, 0, 8, 8);
		addEntry("class1 alone", 1'b1, twoHot(7, 20, 1, 0), 0, 1'b1, 1, 11, 11);
		addEntry("tie at 10", 1'b1, twoHot(0, 13, 7, 24), 0, 1'b1, 0, 10, 0);
		addEntry("tie at 10 again", 1'b1, twoHot(0, 13, 7, 25), 3, 1'b1, 0, 10, 0);
		addEntry("near tie class1", 1'b1, twoHot(0, 13, 7, 26), 0, 1'b1, 1, 11, 1);
		addEntry("near tie class0", 1'b1, twoHot(0, 14, 7, 24), 0, 1'b1, 0, 11, 2);
		addEntry("idle with data", 1'b0, railPattern(CLASS0_WEIGHTS, 1'b1), 1);
		for (int n = 0; n < RANDOM_COUNT; n++)
		begin
			for (int i = 0; i < `NUM_INPUTS; i++)
				act[i] = `ACT_WIDTH'($urandom);
			addEntry($sformatf("random %0d", n), 1'b1, act, int'($urandom_range(0, 1)));
		end
	endtask

	// ------------------------------
	// Checking
	// ------------------------------

	task automatic checkValue(string sigName, logic [`ACT_WIDTH-1:0] actual,
		logic [`ACT_WIDTH-1:0] expected);
		if (actual !== expected)
		begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", sigName, actual, expected);
			errorCount++;
		end
	endtask

	always @(negedge clk)
	begin : monitor
		pending_t head;
		int errorsBefore;
		if (reset)
		begin
			if (decision.valid === 1'b1)
			begin
				$display("decision.valid is high while reset is asserted");
				errorCount++;
			end
		end
		else if (decision.valid)
		begin
			if (pendingQ.size() == 0)
			begin
				$display("decision.valid rose at cycle %0d with no sample in flight", cycleCount);
				errorCount++;
			end
			else
			begin
				head = pendingQ.pop_front();
				errorsBefore = errorCount;
				if (head.dueCycle != cycleCount)
				begin
					$display("Decision for %s came at cycle %0d instead of cycle %0d",
						head.name, cycleCount, head.dueCycle);
					errorCount++;
				end
				checkValue("decision.classId", `ACT_WIDTH'(decision.classId),
					`ACT_WIDTH'(head.expected.classId));
				checkValue("decision.score", decision.score, head.expected.score);
				checkValue("decision.margin", decision.margin, head.expected.margin);
				testsDone++;
				$display("Test %0d %s: %s", testsDone, head.name,
					(errorCount == errorsBefore) ? "ok" : "mismatch");
			end
		end
		else if (pendingQ.size() != 0 && pendingQ[0].dueCycle < cycleCount)
		begin
			head = pendingQ.pop_front();
			$display("No decision arrived for %s at cycle %0d", head.name, head.dueCycle);
			errorCount++;
		end
	end

	// ------------------------------
	// Main sequence
	// ------------------------------

	initial
	begin : driver
		pending_t pend;
		int assertFails;
		reset <= 1'b1;
		sample <= '0;
		void'($urandom(62629));
		buildTable();
		tableReady = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		foreach (stimTable[k])
		begin
			@(posedge clk);
			sample.valid <= stimTable[k].valid;
			sample.act <= stimTable[k].act;
			if (stimTable[k].valid)
			begin
				pend.name = stimTable[k].name;
				pend.expected = stimTable[k].handChecked ? stimTable[k].expected
					: predictDecision(stimTable[k].act);
				pend.dueCycle = cycleCount + LATENCY + 1; // DUT takes it on the next edge
				pendingQ.push_back(pend);
				validCount++;
			end
			repeat (stimTable[k].idleAfter)
			begin
				@(posedge clk);
				sample.valid <= 1'b0;
			end
		end
		@(posedge clk);
		sample <= '0;
		wait (pendingQ.size() == 0);
		repeat (LATENCY + 2) @(posedge clk); // Room for a stray strobe to show up
		if (testsDone != validCount)
		begin
			$display("Only %0d of %0d valid samples produced a checked decision",
				testsDone, validCount);
			errorCount++;
		end
		assertFails = u_classifierTop.u_classifierAssert.failCount;
		$display("Summary: %0d tests, %0d check errors, %0d assertion failures",
			testsDone, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin : watchdog
		int limitCycles;
		wait (tableReady);
		limitCycles = stimTable.size() * 20 + 100;
		#(limitCycles * CLK_PERIOD);
		$display("Timeout after %0d cycles with %0d decisions outstanding",
			limitCycles, pendingQ.size());
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/classifier_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "neural_defines.svh"

module classifierAssert
	import neuralPkg::*;
(
	input logic clk,
	input logic reset,
	input actVector_t sample,
	input neuronOut_t scoreA,
	input neuronOut_t scoreB,
	input decision_t decision
);

	localparam logic [`ACT_WIDTH-1:0] SCORE_CEIL = `SCORE_MAX;

	int failCount = 0;

	// ------------------------------
	// Latency and range
	// ------------------------------

	validToDecision: assert property (@(posedge clk) disable iff (reset)
		sample.valid |-> ##4 decision.valid)
	else
	begin
		$error("decision.valid missing four cycles after sample.valid");
		failCount++;
	end

	decisionFromSample: assert property (@(posedge clk) disable iff (reset)
		decision.valid |-> $past(sample.valid, 4))
	else
	begin
		$error("decision.valid without a valid sample four cycles earlier");
		failCount++;
	end

	scoreCeiling: assert property (@(posedge clk) disable iff (reset)
		decision.valid |-> decision.score <= SCORE_CEIL)
	else
	begin
		$error("Winning score above the saturation ceiling");
		failCount++;
	end

	// The edge after a reset edge sees cleared registers
	quietAfterReset: assert property (@(posedge clk)
		reset |=> !scoreA.valid && !scoreB.valid && !decision.valid)
	else
	begin
		$error("Valid strobe high during or just after reset");
		failCount++;
	end

endmodule

bind classifierTop classifierAssert u_classifierAssert (
	.clk (clk),
	.reset (reset),
	.sample (sample),
	.scoreA (scoreA),
	.scoreB (scoreB),
	.decision (decision)
);

`default_nettype wire

// ==== verilog/classifierTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module classifierTop
	import neuralPkg::*;
(
	input logic clk,
	input logic reset,
	input actVector_t sample,
	output decision_t decision
);

	neuronOut_t scoreA; // Class 0 score
	neuronOut_t scoreB; // Class 1 score

	// ------------------------------
	// Class neurons
	// ------------------------------

	// Both neurons see the same sample on the same edge
	denseNeuron #(
		.WEIGHTS (CLASS0_WEIGHTS),
		.BIAS (CLASS0_BIAS)
	) u_class0Neuron (
		.clk (clk),
		.reset (reset),
		.sample (sample),
		.result (scoreA)
	);

	denseNeuron #(
		.WEIGHTS (CLASS1_WEIGHTS),
		.BIAS (CLASS1_BIAS)
	) u_class1Neuron (
		.clk (clk),
		.reset (reset),
		.sample (sample),
		.result (scoreB)
	);

	// ------------------------------
	// Decision stage
	// ------------------------------

	scorePicker u_scorePicker (
		.clk (clk),
		.reset (reset),
		.scoreA (scoreA),
		.scoreB (scoreB),
		.decision (decision)
	);

endmodule

`default_nettype wire

// ==== verilog/scorePicker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "neural_defines.svh"

module scorePicker
	import neuralPkg::*;
(
	input logic clk,
	input logic reset,
	input neuronOut_t scoreA,
	input neuronOut_t scoreB,
	output decision_t decision
);

	logic bWins;
	logic [`ACT_WIDTH-1:0] winScore;
	logic [`ACT_WIDTH-1:0] loseScore;
	logic [`ACT_WIDTH-1:0] margin;
	decision_t decisionNext;

	// ------------------------------
	// Comparison
	// ------------------------------

	// Strictly greater, so a tie stays with class 0
	assign bWins = scoreB.score > scoreA.score;

	always_comb
	begin
		if (bWins)
		begin
			winScore = scoreB.score;
			loseScore = scoreA.score;
		end
		else
		begin
			winScore = scoreA.score;
			loseScore = scoreB.score;
		end
	end

	assign margin = winScore - loseScore; // Never negative after the swap

	// ------------------------------
	// Decision register
	// ------------------------------

	always_comb
	begin
		decisionNext.valid = scoreA.valid; // The neurons run in lockstep
		decisionNext.classId = bWins;
		decisionNext.score = winScore;
		decisionNext.margin = margin;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			decision <= '0;
		else
			decision <= decisionNext;
	end

endmodule

`default_nettype wire

// ==== verilog/denseNeuron.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "neural_defines.svh"

module denseNeuron
	import neuralPkg::*;
#(
	parameter weightTable_t WEIGHTS = '0,
	parameter bias_t BIAS = '0
)
(
	input logic clk,
	input logic reset,
	input actVector_t sample,
	output neuronOut_t result
);

	// Bit positions inside the accumulator
	localparam int SIGN_BIT = `ACC_WIDTH - 1;
	localparam int INT_LSB = `FRAC_BITS;
	localparam int INT_MSB = `FRAC_BITS + `ACT_WIDTH - 2; // Seven integer bits below the ceiling
	localparam int OVF_LSB = INT_MSB + 1;
	localparam logic [`ACT_WIDTH-1:0] SCORE_CEIL = `SCORE_MAX;

	actVector_t sampleReg;

	logic signed [2*`ACT_WIDTH-1:0] product [`NUM_INPUTS];
	logic signed [`ACC_WIDTH-1:0] sumNext;
	logic signed [`ACC_WIDTH-1:0] accReg;
	logic accValid;

	logic [`ACT_WIDTH-2:0] intPart;
	logic roundBit;
	logic overflow;
	logic [`ACT_WIDTH-1:0] rounded;
	logic [`ACT_WIDTH-1:0] scoreNext;

	// ------------------------------
	// Stage 1: input register
	// ------------------------------

	always_ff @(posedge clk)
	begin
		if (reset)
			sampleReg <= '0;
		else
			sampleReg <= sample; // Valid travels with its vector
	end

	// ------------------------------
	// Stage 2: multiply-accumulate
	// ------------------------------

	always_comb
	begin
		for (int i = 0; i < `NUM_INPUTS; i++)
			product[i] = $signed(sampleReg.act[i]) * $signed(WEIGHTS[i]); // Q2.12 product
	end

	always_comb
	begin
		sumNext = BIAS; // Bias is already in product format
		for (int i = 0; i < `NUM_INPUTS; i++)
			sumNext = sumNext + product[i];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			accReg <= '0;
			accValid <= 1'b0;
		end
		else
		begin
			accReg <= sumNext;
			accValid <= sampleReg.valid;
		end
	end

	// ------------------------------
	// Stage 3: ReLU, saturate, round
	// ------------------------------

	assign intPart = accReg[INT_MSB:INT_LSB];
	assign roundBit = accReg[INT_LSB-1]; // Half an output step
	assign overflow = |accReg[SIGN_BIT-1:OVF_LSB];
	assign rounded = {1'b0, intPart} + `ACT_WIDTH'(roundBit);

	always_comb
	begin
		if (accReg[SIGN_BIT])
			scoreNext = '0; // ReLU clamps negative sums
		else if (overflow)
			scoreNext = SCORE_CEIL;
		else if (rounded > SCORE_CEIL)
			scoreNext = SCORE_CEIL; // Rounding up from 127 would pass the ceiling
		else
			scoreNext = rounded;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			result <= '0;
		else
		begin
			result.valid <= accValid;
			result.score <= scoreNext;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/neuralPkg.sv ====
`default_nettype none

`include "neural_defines.svh"

package neuralPkg;

	// ------------------------------
	// Element types
	// ------------------------------

	typedef logic signed [`ACT_WIDTH-1:0] activation_t;

	typedef logic signed [2*`ACT_WIDTH-1:0] bias_t; // Same format as a product

	// Index 0 is the leftmost entry of a table literal
	typedef logic [0:`NUM_INPUTS-1][`ACT_WIDTH-1:0] weightTable_t;

	// ------------------------------
	// Datapath structs
	// ------------------------------

	typedef struct packed
	{
		logic valid; // One-cycle strobe
		logic [`NUM_INPUTS-1:0][`ACT_WIDTH-1:0] act; // Signed Q1.6 activations
	} actVector_t;

	typedef struct packed
	{
		logic valid;
		logic [`ACT_WIDTH-1:0] score; // Unsigned after ReLU
	} neuronOut_t;

	typedef struct packed
	{
		logic valid;
		logic classId; // Set when class 1 wins
		logic [`ACT_WIDTH-1:0] score; // Score of the winning class
		logic [`ACT_WIDTH-1:0] margin; // Absolute score difference
	} decision_t;

	// ------------------------------
	// Fixed weight tables
	// ------------------------------

	localparam weightTable_t CLASS0_WEIGHTS = '{
		8'sd62,
		8'sd24,
		-8'sd12,
		8'sd28,
		8'sd26,
		8'sd54,
		-8'sd32,
		8'sd14,
		8'sd14,
		8'sd16,
		-8'sd36,
		-8'sd42,
		-8'sd54,
		8'sd22,
		8'sd38
	};

	localparam bias_t CLASS0_BIAS = -16'sd512;

	localparam weightTable_t CLASS1_WEIGHTS = '{
		-8'sd20,
		8'sd40,
		8'sd18,
		-8'sd8,
		8'sd30,
		-8'sd44,
		8'sd12,
		8'sd50,
		-8'sd26,
		8'sd10,
		8'sd34,
		8'sd6,
		-8'sd16,
		8'sd46,
		-8'sd30
	};

	localparam bias_t CLASS1_BIAS = -16'sd320;

endpackage

`default_nettype wire

// ==== verilog/neural_defines.svh ====
`ifndef NEURAL_DEFINES_SVH
`define NEURAL_DEFINES_SVH

// ------------------------------
// Sample geometry
// ------------------------------

`define NUM_INPUTS 15 // Activations per sample

`define ACT_WIDTH 8 // Bits per activation, weight and score

`define FRAC_BITS 6 // Fraction bits of activations and weights

// ------------------------------
// Datapath sizing
// ------------------------------

// Sixteen-bit products plus headroom for 15 products and the bias
`define ACC_WIDTH 23

`define SCORE_MAX 127 // Ceiling of an 8-bit class score

`endif
